//--- bench/cart_download_chk.sv
`timescale 1ns/1ns
// Concurrent assertions on the download front end ports
// Bound into every cart_download instance
module cart_download_chk (
	input logic clk,
	input logic reset_nes,
	input logic dl_active,
	input logic mem_write,
	input logic loader_done,
	input logic loader_fail,
	input logic cheat_valid
);

	// Single cycle code strobe
	valid_pulse: assert property (@(posedge clk) disable iff (reset_nes)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid stayed high for more than one cycle");

	// Memory writes only happen inside a download
	write_in_download: assert property (@(posedge clk) disable iff (reset_nes)
		mem_write |-> dl_active)
		else $error("mem_write asserted while dl_active is low");

	status_reset: assert property (@(posedge clk)
		reset_nes |=> (!loader_done && !loader_fail))
		else $error("loader_done or loader_fail high after reset");

endmodule

bind cart_download cart_download_chk chk_i (
	.clk         (clk),
	.reset_nes   (reset_nes),
	.dl_active   (dl_active),
	.mem_write   (mem_write),
	.loader_done (loader_done),
	.loader_fail (loader_fail),
	.cheat_valid (cheat_valid)
);

//--- bench/tb_cart_download.sv
`timescale 1ns/1ns
// Testbench for the cartridge download front end. Sends random ROM and cheat
// files from a fixed seed and checks writes, flags, reset hold and cheat codes
module tb_cart_download;

	localparam int HOLD       = 40;    // Short console reset hold
	localparam int WAIT_LIMIT = 1000;

	logic                                clk;
	logic                                reset_nes;
	logic                                dl_active;
	logic [7:0]                          dl_index;
	logic [nes_cart_pkg::DL_ADDR_W-1:0]  dl_addr;
	logic                                dl_wr;
	logic [7:0]                          dl_data;
	logic                                invert_mirroring;
	logic [nes_cart_pkg::MEM_ADDR_W-1:0] mem_addr;
	logic [7:0]                          mem_data;
	logic                                mem_write;
	logic [nes_cart_pkg::FLAGS_W-1:0]    mapper_flags;
	logic                                loader_busy;
	logic                                loader_done;
	logic                                loader_fail;
	logic [nes_cart_pkg::CHEAT_W-1:0]    cheat_code;
	logic                                cheat_valid;
	logic                                cheat_clear;
	logic                                nes_reset;

	logic [31:0] rnd_state;
	string       test_name;
	int          write_count;
	logic [7:0]  hdr [16];                 // Header of the current ROM file

	cart_download #(.RESET_HOLD(HOLD)) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(negedge clk) begin
		if (mem_write === 1'b1)
			write_count++;
	end

	function automatic logic [31:0] next_rand();
		rnd_state ^= rnd_state << 13;
		rnd_state ^= rnd_state >> 17;
		rnd_state ^= rnd_state << 5;
		return rnd_state;
	endfunction

	task automatic fail_stop(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string what, input logic [127:0] expected,
	                     input logic [127:0] actual);
		if (expected !== actual)
			fail_stop($sformatf("MISMATCH %s %s expected %0h actual %0h",
			                    test_name, what, expected, actual));
	endtask

	////////////////////////////////////////////////////////////////////
	// Header model
	////////////////////////////////////////////////////////////////////

	function automatic logic [2:0] size_code_model(input logic [7:0] pages);
		for (int k = 0; k < 7; k++) begin
			if (int'(pages) <= (1 << k))
				return 3'(k);
		end
		return 3'd7;
	endfunction

	function automatic logic [31:0] flags_model(input logic inv);
		logic        nes20;
		logic        tail;
		logic [31:0] f;
		nes20 = (hdr[7][3:2] == 2'b10);
		tail  = (hdr[9][7:1] != 7'd0);
		for (int i = 10; i < 16; i++)
			tail = tail || (hdr[i] != 8'd0);
		f        = '0;
		f[7:0]   = {(!nes20 && tail) ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};  // Dirty drops nibble
		f[10:8]  = size_code_model(hdr[4]);
		f[13:11] = size_code_model(hdr[5]);
		f[14]    = hdr[6][0] ^ inv;
		f[15]    = (hdr[5] == 8'd0);
		f[16]    = hdr[6][3];
		f[24:17] = nes20 ? hdr[8] : 8'h00;
		f[25]    = hdr[6][1];
		return f;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////

	task automatic send_byte(input logic [7:0] data,
	                         input logic [nes_cart_pkg::DL_ADDR_W-1:0] addr,
	                         input logic want_write,
	                         input logic [nes_cart_pkg::MEM_ADDR_W-1:0] want_addr,
	                         input logic cheat);
		int gap;
		gap = 2 + int'(next_rand() % 2);   // Strobes 2 or 3 cycles apart
		repeat (gap - 1) @(posedge clk);
		dl_wr   <= 1'b1;
		dl_data <= data;
		dl_addr <= addr;
		@(negedge clk);
		check("mem_write", want_write, mem_write);
		if (want_write) begin
			check("mem_addr", want_addr, mem_addr);
			check("mem_data", data, mem_data);
		end
		if (!cheat) begin
			check("nes_reset during download", 1'b1, nes_reset);
			check("loader_busy", want_write, loader_busy);  // High only in the image phases
		end
		@(posedge clk);
		dl_wr <= 1'b0;
		@(negedge clk);
		check("cheat_clear", cheat && (addr[3:0] == 4'd0), cheat_clear);
		check("cheat_valid", cheat && (addr[3:0] == 4'd15), cheat_valid);
	endtask

	task automatic start_file(input logic [7:0] index, input logic inv);
		@(posedge clk);
		dl_active        <= 1'b1;
		dl_index         <= index;
		invert_mirroring <= inv;
	endtask

	task automatic end_file();
		@(posedge clk);
		dl_active <= 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (loader_done !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				fail_stop($sformatf("%s: loader_done never rose", test_name));
		end
	endtask

	// Modes 0 clean iNES, 1 NES 2.0, 2 dirty, 3 bad magic, 4 trainer
	task automatic rom_load(input int mode, input logic inv);
		int   prg_bytes;
		int   chr_bytes;
		int   n;
		logic bad;
		test_name = $sformatf("rom_load mode %0d", mode);
		hdr[0] = 8'h4E;
		hdr[1] = 8'h45;
		hdr[2] = 8'h53;
		hdr[3] = 8'h1A;
		for (int i = 4; i < 16; i++)
			hdr[i] = 8'(next_rand());
		hdr[4] = 8'(1 + next_rand() % 2);
		hdr[5] = (mode == 1) ? 8'h00 : 8'(next_rand() % 2);  // CHR RAM for the NES 2.0 load
		hdr[6] = hdr[6] & 8'hFB;
		hdr[7] = (mode == 1) ? ((hdr[7] & 8'hF3) | 8'h08) : (hdr[7] & 8'hF3);
		if (mode != 1 && mode != 2) begin
			hdr[9] = hdr[9] & 8'h01;
			for (int i = 10; i < 16; i++)
				hdr[i] = 8'h00;
		end
		if (mode == 2)
			hdr[13] = hdr[13] | 8'h10;
		if (mode == 3)
			hdr[2] = 8'h54;
		if (mode == 4)
			hdr[6] = hdr[6] | 8'h04;
		bad       = (mode >= 3);
		prg_bytes = int'(hdr[4]) << 14;
		chr_bytes = int'(hdr[5]) << 13;
		write_count = 0;
		start_file(8'h01, inv);
		for (int i = 0; i < 16; i++)
			send_byte(hdr[i], i, 1'b0, '0, 1'b0);
		if (bad) begin
			wait_done();
			check("loader_fail", 1'b1, loader_fail);
			for (int i = 0; i < 8; i++)
				send_byte(8'(next_rand()), 16 + i, 1'b0, '0, 1'b0);
			end_file();
			@(negedge clk);
			repeat (HOLD + 10) begin
				check("nes_reset after bad header", 1'b1, nes_reset);
				@(negedge clk);
			end
		end else begin
			for (int i = 0; i < prg_bytes + chr_bytes; i++)
				send_byte(8'(next_rand()), 16 + i, 1'b1,
				          (i < prg_bytes) ? i : 32'h20_0000 + (i - prg_bytes), 1'b0);
			end_file();                       // Loader may still be busy here
			@(negedge clk);
			wait_done();
			check("loader_fail", 1'b0, loader_fail);
			check("loader_busy", 1'b0, loader_busy);
			check("mapper_flags", flags_model(inv), mapper_flags);
			// Hold counts from the first cycle with both download and busy low
			n = 0;
			while (nes_reset === 1'b1) begin
				n++;
				if (n > HOLD + WAIT_LIMIT)
					fail_stop($sformatf("%s: nes_reset never fell", test_name));
				@(negedge clk);
			end
			check("reset hold cycles", HOLD, n);
		end
		check("write count", bad ? 0 : prg_bytes + chr_bytes, write_count);
	endtask

	task automatic cheat_file();
		logic [127:0]                       code;
		logic [31:0]                        flags_before;
		logic                               done_before;
		logic                               fail_before;
		logic                               reset_before;
		logic [nes_cart_pkg::DL_ADDR_W-1:0] base;
		logic [7:0]                         b;
		test_name    = "cheat_file";
		flags_before = mapper_flags;
		done_before  = loader_done;
		fail_before  = loader_fail;
		reset_before = nes_reset;
		base         = next_rand() << 4;
		code         = '0;
		write_count  = 0;
		start_file(8'hFF, invert_mirroring);
		for (int i = 0; i < 16; i++) begin
			b = 8'(next_rand());
			code[(3 - i / 4) * 32 + (i % 4) * 8 +: 8] = b;  // Flags group on top
			send_byte(b, base + i, 1'b0, '0, 1'b1);
		end
		check("cheat_code", code, cheat_code);
		end_file();
		@(negedge clk);
		check("write count", 0, write_count);
		check("mapper_flags", flags_before, mapper_flags);
		check("loader_done", done_before, loader_done);
		check("loader_fail", fail_before, loader_fail);
		check("nes_reset", reset_before, nes_reset);
	endtask

	initial begin
		rnd_state        = 32'd6;
		reset_nes        = 1'b1;
		dl_active        = 1'b0;
		dl_index         = 8'h00;
		dl_addr          = '0;
		dl_wr            = 1'b0;
		dl_data          = 8'h00;
		invert_mirroring = 1'b0;
		write_count      = 0;
		test_name        = "reset";
		repeat (8) @(posedge clk);
		reset_nes <= 1'b0;
		@(negedge clk);
		check("loader_busy", 1'b0, loader_busy);
		check("loader_done", 1'b0, loader_done);
		check("loader_fail", 1'b0, loader_fail);
		check("mem_write", 1'b0, mem_write);
		check("cheat_valid", 1'b0, cheat_valid);
		check("cheat_clear", 1'b0, cheat_clear);
		check("nes_reset", 1'b1, nes_reset);
		cheat_file();                       // No ROM yet, console stays in reset
		rom_load(0, 1'b0);
		rom_load(1, 1'b1);
		cheat_file();
		rom_load(3, 1'b0);
		cheat_file();
		rom_load(2, 1'b1);
		rom_load(4, 1'b1);
		rom_load(2, 1'b0);
		cheat_file();
		$display("Regression passed");
		$finish;
	end

endmodule

//--- logic/cart_download.sv
`timescale 1ns/1ns
// Top of the cartridge download front end. Splits the host byte stream into
// ROM and cheat traffic and holds the console in reset around a ROM load
module cart_download #(
	parameter int RESET_HOLD = 255
) (
	input  logic                                clk,
	input  logic                                reset_nes,
	input  logic                                dl_active,
	input  logic [7:0]                          dl_index,
	input  logic [nes_cart_pkg::DL_ADDR_W-1:0]  dl_addr,
	input  logic                                dl_wr,
	input  logic [7:0]                          dl_data,
	input  logic                                invert_mirroring,
	output logic [nes_cart_pkg::MEM_ADDR_W-1:0] mem_addr,
	output logic [7:0]                          mem_data,
	output logic                                mem_write,
	output logic [nes_cart_pkg::FLAGS_W-1:0]    mapper_flags,
	output logic                                loader_busy,
	output logic                                loader_done,
	output logic                                loader_fail,
	output logic [nes_cart_pkg::CHEAT_W-1:0]    cheat_code,
	output logic                                cheat_valid,
	output logic                                cheat_clear,
	output logic                                nes_reset
);

	localparam int HOLD_W = $clog2(RESET_HOLD + 2);

	logic              is_cheat;
	logic              rom_active;
	logic              rom_active_q;
	logic              loader_restart;
	logic              dl_started;
	logic [HOLD_W-1:0] hold_cnt;

	assign is_cheat   = (dl_index == nes_cart_pkg::FILETYPE_CHEAT);
	assign rom_active = dl_active && !is_cheat;

	// Restart on reset or at the start of each ROM download
	assign loader_restart = reset_nes || (rom_active && !rom_active_q);

	rom_loader #(
		.MEM_ADDR_W (nes_cart_pkg::MEM_ADDR_W)
	) loader_i (
		.clk              (clk),
		.restart          (loader_restart),
		.byte_wr          (dl_wr && rom_active),
		.byte_data        (dl_data),
		.invert_mirroring (invert_mirroring),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.mapper_flags     (mapper_flags),
		.busy             (loader_busy),
		.done             (loader_done),
		.fail             (loader_fail)
	);

	cheat_capture cheat_i (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.byte_wr     (dl_wr && dl_active && is_cheat),
		.byte_index  (dl_addr[3:0]),
		.byte_data   (dl_data),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	////////////////////////////////////////////////////////////////////
	// Console reset hold
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			rom_active_q <= 1'b0;
			dl_started   <= 1'b0;
			hold_cnt     <= '0;
		end else begin
			rom_active_q <= rom_active;
			if (rom_active)
				dl_started <= 1'b1;
			if (rom_active)
				hold_cnt <= HOLD_W'(RESET_HOLD);
			else if (!loader_busy && hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;  // Waits for the last image bytes
		end
	end

	assign nes_reset = reset_nes || !dl_started || rom_active || loader_fail ||
	                   (hold_cnt != '0);

endmodule

//--- logic/cheat_capture.sv
`timescale 1ns/1ns
// Builds one 128-bit cheat code from 16 cheat file bytes
// Fields from the top are flags, address, compare and replace, each little endian
module cheat_capture (
	input  logic                             clk,
	input  logic                             reset_nes,
	input  logic                             byte_wr,
	input  logic [3:0]                       byte_index,
	input  logic [7:0]                       byte_data,
	output logic [nes_cart_pkg::CHEAT_W-1:0] cheat_code,
	output logic                             cheat_valid,
	output logic                             cheat_clear
);

	logic [6:0] byte_lsb;
	logic       last_byte;
	logic       first_byte;

	// Group i/4 counts down from the top word, byte i%4 within it
	assign byte_lsb = {~byte_index[3:2], byte_index[1:0], 3'b000};

	assign last_byte  = (byte_index == 4'd15);
	assign first_byte = (byte_index == 4'd0);

	always_ff @(posedge clk) begin
		if (byte_wr)
			cheat_code[byte_lsb +: 8] <= byte_data;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= byte_wr && last_byte;   // Code complete
			cheat_clear <= byte_wr && first_byte;  // New cheat file
		end
	end

endmodule

//--- logic/ines_header.sv
`timescale 1ns/1ns
// Holds the 16 iNES header bytes and decodes them into the mapper flag vector
// Decode outputs are combinational from the stored bytes
module ines_header (
	input  logic                             clk,
	input  logic                             hdr_wr,
	input  logic [3:0]                       hdr_index,
	input  logic [7:0]                       hdr_data,
	input  logic                             invert_mirroring,
	output logic                             header_ok,
	output logic [7:0]                       prg_pages,
	output logic [7:0]                       chr_pages,
	output logic [nes_cart_pkg::FLAGS_W-1:0] mapper_flags
);

	logic [7:0] hdr_mem [16];

	logic       magic_ok;
	logic       is_nes20;
	logic       is_dirty;
	logic       tail_nonzero;
	logic [7:0] mapper_num;
	logic [7:0] submapper;

	always_ff @(posedge clk) begin
		if (hdr_wr)
			hdr_mem[hdr_index] <= hdr_data;
	end

	////////////////////////////////////////////////////////////////////
	// Header checks
	////////////////////////////////////////////////////////////////////

	assign magic_ok = (hdr_mem[0] == nes_cart_pkg::INES_MAGIC0) &&
	                  (hdr_mem[1] == nes_cart_pkg::INES_MAGIC1) &&
	                  (hdr_mem[2] == nes_cart_pkg::INES_MAGIC2) &&
	                  (hdr_mem[3] == nes_cart_pkg::INES_MAGIC3);

	assign header_ok = magic_ok && !hdr_mem[6][2];  // Trainers not supported

	assign prg_pages = hdr_mem[4];
	assign chr_pages = hdr_mem[5];

	// NES 2.0 marks byte 7 bits 3:2 as 2'b10
	assign is_nes20 = (hdr_mem[7][3:2] == 2'b10);

	assign tail_nonzero = (hdr_mem[9][7:1] != 7'd0) ||
	                      (hdr_mem[10] != 8'd0) || (hdr_mem[11] != 8'd0) ||
	                      (hdr_mem[12] != 8'd0) || (hdr_mem[13] != 8'd0) ||
	                      (hdr_mem[14] != 8'd0) || (hdr_mem[15] != 8'd0);

	// Junk in the tail of an old header, so byte 7 is not trusted
	assign is_dirty = !is_nes20 && tail_nonzero;

	assign mapper_num = {is_dirty ? 4'h0 : hdr_mem[7][7:4], hdr_mem[6][7:4]};
	assign submapper  = is_nes20 ? hdr_mem[8] : 8'h00;

	////////////////////////////////////////////////////////////////////
	// Flag vector
	////////////////////////////////////////////////////////////////////

	always_comb begin
		mapper_flags = '0;
		mapper_flags[nes_cart_pkg::FLAG_MAPPER_HI:nes_cart_pkg::FLAG_MAPPER_LO] = mapper_num;
		mapper_flags[nes_cart_pkg::FLAG_PRG_SIZE_HI:nes_cart_pkg::FLAG_PRG_SIZE_LO] =
			nes_cart_pkg::size_code(prg_pages);
		mapper_flags[nes_cart_pkg::FLAG_CHR_SIZE_HI:nes_cart_pkg::FLAG_CHR_SIZE_LO] =
			nes_cart_pkg::size_code(chr_pages);
		mapper_flags[nes_cart_pkg::FLAG_MIRROR]      = hdr_mem[6][0] ^ invert_mirroring;
		mapper_flags[nes_cart_pkg::FLAG_CHR_RAM]     = (chr_pages == 8'd0);
		mapper_flags[nes_cart_pkg::FLAG_FOUR_SCREEN] = hdr_mem[6][3];
		mapper_flags[nes_cart_pkg::FLAG_SUBMAPPER_HI:nes_cart_pkg::FLAG_SUBMAPPER_LO] =
			submapper;
		mapper_flags[nes_cart_pkg::FLAG_HAS_SAVES]   = hdr_mem[6][1];  // Battery RAM
	end

endmodule

//--- logic/nes_cart_pkg.sv
// Shared widths, file codes and iNES field positions for the cartridge download path
// Compile this first. Other files refer to its items by scoped name
package nes_cart_pkg;

	localparam int MEM_ADDR_W = 22;              // Cartridge memory address
	localparam int DL_ADDR_W  = 25;              // Host byte address
	localparam int FLAGS_W    = 32;
	localparam int CHEAT_W    = 128;

	localparam logic [7:0] FILETYPE_CHEAT = 8'hFF;
	localparam logic [21:0] CHR_BASE      = 22'h20_0000;

	localparam int PRG_PAGE_SHIFT = 14;          // 16 KiB pages
	localparam int CHR_PAGE_SHIFT = 13;          // 8 KiB pages

	localparam logic [7:0] INES_MAGIC0 = 8'h4E;  // N
	localparam logic [7:0] INES_MAGIC1 = 8'h45;  // E
	localparam logic [7:0] INES_MAGIC2 = 8'h53;  // S
	localparam logic [7:0] INES_MAGIC3 = 8'h1A;

	// Mapper flag vector layout, bits 31:26 stay zero
	localparam int FLAG_MAPPER_LO    = 0;
	localparam int FLAG_MAPPER_HI    = 7;
	localparam int FLAG_PRG_SIZE_LO  = 8;
	localparam int FLAG_PRG_SIZE_HI  = 10;
	localparam int FLAG_CHR_SIZE_LO  = 11;
	localparam int FLAG_CHR_SIZE_HI  = 13;
	localparam int FLAG_MIRROR       = 14;
	localparam int FLAG_CHR_RAM      = 15;
	localparam int FLAG_FOUR_SCREEN  = 16;
	localparam int FLAG_SUBMAPPER_LO = 17;
	localparam int FLAG_SUBMAPPER_HI = 24;
	localparam int FLAG_HAS_SAVES    = 25;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_ERROR,
		LOAD_DONE
	} loader_state_t;

	// Smallest k with pages <= 2**k, saturates at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd0;
		for (int k = 0; k < 7; k++) begin
			if ({1'b0, pages} > (9'd1 << k)) code = 3'(k + 1);
		end
		return code;
	endfunction

endpackage

//--- logic/rom_loader.sv
`timescale 1ns/1ns
// ROM loader FSM. Feeds the header bytes to the decoder, then walks the PRG
// image from address 0 and the CHR image from CHR_BASE, one write per byte
module rom_loader #(
	parameter int MEM_ADDR_W = 22
) (
	input  logic                             clk,
	input  logic                             restart,
	input  logic                             byte_wr,
	input  logic [7:0]                       byte_data,
	input  logic                             invert_mirroring,
	output logic [MEM_ADDR_W-1:0]            mem_addr,
	output logic [7:0]                       mem_data,
	output logic                             mem_write,
	output logic [nes_cart_pkg::FLAGS_W-1:0] mapper_flags,
	output logic                             busy,
	output logic                             done,
	output logic                             fail
);

	nes_cart_pkg::loader_state_t state;

	logic [3:0]            hdr_cnt;
	logic [MEM_ADDR_W-1:0] bytes_left;
	logic                  hdr_wr;
	logic                  header_ok;
	logic [7:0]            prg_pages;
	logic [7:0]            chr_pages;
	logic                  in_image;
	logic                  bytes_pending;

	assign hdr_wr        = byte_wr && (state == nes_cart_pkg::LOAD_HEADER);
	assign in_image      = (state == nes_cart_pkg::LOAD_PRG) || (state == nes_cart_pkg::LOAD_CHR);
	assign bytes_pending = (bytes_left != '0);

	// Zero latency write path
	assign mem_write = byte_wr && in_image && bytes_pending;
	assign mem_data  = byte_data;

	ines_header hdr_i (
		.clk              (clk),
		.hdr_wr           (hdr_wr),
		.hdr_index        (hdr_cnt),
		.hdr_data         (byte_data),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.mapper_flags     (mapper_flags)
	);

	always_ff @(posedge clk) begin
		if (restart) begin
			state      <= nes_cart_pkg::LOAD_HEADER;
			hdr_cnt    <= 4'd0;
			bytes_left <= '0;
			mem_addr   <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			fail       <= 1'b0;
		end else begin
			case (state)
				nes_cart_pkg::LOAD_HEADER: begin
					if (byte_wr) begin
						hdr_cnt <= hdr_cnt + 4'd1;
						if (hdr_cnt == 4'd15) begin
							if (header_ok) begin
								state      <= nes_cart_pkg::LOAD_PRG;
								busy       <= 1'b1;
								mem_addr   <= '0;  // PRG at bottom of map
								bytes_left <= MEM_ADDR_W'(prg_pages) << nes_cart_pkg::PRG_PAGE_SHIFT;
							end else begin
								state <= nes_cart_pkg::LOAD_ERROR;
								done  <= 1'b1;
								fail  <= 1'b1;
							end
						end
					end
				end
				nes_cart_pkg::LOAD_PRG, nes_cart_pkg::LOAD_CHR: begin
					if (bytes_pending) begin
						if (byte_wr) begin
							bytes_left <= bytes_left - 1'b1;
							mem_addr   <= mem_addr + 1'b1;
						end
					end else if (state == nes_cart_pkg::LOAD_PRG) begin
						state      <= nes_cart_pkg::LOAD_CHR;
						mem_addr   <= MEM_ADDR_W'(nes_cart_pkg::CHR_BASE);
						bytes_left <= MEM_ADDR_W'(chr_pages) << nes_cart_pkg::CHR_PAGE_SHIFT;
					end else begin
						state <= nes_cart_pkg::LOAD_DONE;
						done  <= 1'b1;
						busy  <= 1'b0;
					end
				end
				// Error and done hold until the next restart
				default: state <= state;
			endcase
		end
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the cartridge download testbench with Verilator and runs it.
# Exit status is zero only when the pass message shows up in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cart_download -f vlog.f || exit 1
sim_out="$(./obj_dir/Vtb_cart_download 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Regression passed" && exit 0 || exit 1

//--- vlog.f
logic/nes_cart_pkg.sv
logic/ines_header.sv
logic/rom_loader.sv
logic/cheat_capture.sv
logic/cart_download.sv
bench/cart_download_chk.sv
bench/tb_cart_download.sv
